/* Makefile */
# Verilator flow, run from the project root
TOP := tb_uart_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

obj_dir/V$(TOP): verilog.f hw/*.sv hw/*.svh tb/tb_uart_top.sv
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/uart_baud_tick.sv */
////////////////////////////////////////////////////////////
// Oversampling tick at 4x the bit rate
// Period is divisor + 1 cycles, divisor must be >= 4
// A changed external divisor applies once the count reaches it
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module uart_baud_tick #(
	parameter bit baud_fixed = 1'b1
) (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  uart_pkg::baud_count_t ext_baud_count,
	output logic                  baud_tick
);
	import uart_pkg::*;

	baud_count_t divisor;
	baud_count_t count;

	// Fixed default or external divisor
	assign divisor = baud_fixed ? `UART_BAUD_COUNT_DEFAULT : ext_baud_count;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
			baud_tick <= 1'b0;
		end else if (count >= divisor) begin
			// Also restarts when the divisor shrank below the count
			count <= '0;
			baud_tick <= 1'b1;
		end else begin
			count <= count + 13'd1;
			baud_tick <= 1'b0;
		end
	end

	// Short divisors leave the engines no time between ticks
	a_divisor_min: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		divisor >= `UART_BAUD_COUNT_MIN)
		else $error("baud divisor %0d below minimum", divisor);

endmodule

`default_nettype wire

/* hw/uart_params.svh */
////////////////////////////////////////////////////////////
// Defaults for the UART subsystem
// The divisor is clock / bit rate / 4 - 1 and must be >= 4
// Oversampling is fixed at 4 ticks per bit; RTL relies on it
////////////////////////////////////////////////////////////

`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// 50 MHz clock at 115200 bit/s
`define UART_BAUD_COUNT_DEFAULT 13'd108

// Ticks per bit, a limit of the 2-bit sub-tick counters
`define UART_OVERSAMPLE 4

// Smallest divisor the engines are meant to run with
`define UART_BAUD_COUNT_MIN 13'd4

`endif

/* hw/uart_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the UART subsystem
// Frame position runs 0 (start) .. 9 (stop)
////////////////////////////////////////////////////////////

package uart_pkg;

	// Data byte
	typedef logic [7:0] uart_byte_t;

	// Divisor of the tick generator
	typedef logic [12:0] baud_count_t;

	// Frame position, 1..8 are data bits
	typedef logic [3:0] bit_index_t;

	// Tick position within one bit
	typedef logic [1:0] sub_tick_t;

	// Transmit FSM
	typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

	// Receive FSM
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

/* hw/uart_receiver.sv */
////////////////////////////////////////////////////////////
// 8N1 receiver, 4x oversampled, one sample per bit
// Needs a falling edge to start; start low is confirmed
// Byte is reported at the stop bit's mid-sample
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module uart_receiver (
	input  logic                 iCLOCK,
	input  logic                 inRESET,
	input  logic                 baud_tick,
	input  logic                 rxd,
	output logic                 rx_valid,
	output uart_pkg::uart_byte_t rx_data,
	output logic                 rx_frame_err
);
	import uart_pkg::*;

	// Second tick of each bit
	localparam sub_tick_t sub_mid = sub_tick_t'(`UART_OVERSAMPLE / 2 - 1);
	localparam bit_index_t bit_last_data = 4'd8;
	localparam bit_index_t bit_stop = 4'd9;

	rx_state_t  state;
	bit_index_t bit_idx;
	sub_tick_t  sub_tick;
	uart_byte_t shift_q;

	// Synchronizer and edge history
	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;

	logic fall_edge;
	logic mid_sample;

	assign fall_edge = rxd_prev && !rxd_sync;
	assign mid_sample = baud_tick && (sub_tick == sub_mid);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			// Line idles high
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	// Data bits in LSB first
	always_ff @(posedge iCLOCK) begin
		if (state == RX_DATA && mid_sample) begin
			shift_q <= {rxd_sync, shift_q[7:1]};
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= RX_IDLE;
			bit_idx <= '0;
			sub_tick <= '0;
			rx_valid <= 1'b0;
			rx_data <= '0;
			rx_frame_err <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			// Tick phase is counted from the start edge
			if (baud_tick) begin
				sub_tick <= sub_tick + 2'd1;
			end
			case (state)
				RX_IDLE: begin
					sub_tick <= '0;
					bit_idx <= '0;
					if (fall_edge) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (mid_sample) begin
						if (rxd_sync) begin
							// Glitch, drop without a pulse
							state <= RX_IDLE;
						end else begin
							state <= RX_DATA;
							bit_idx <= 4'd1;
						end
					end
				end
				RX_DATA: begin
					if (mid_sample) begin
						if (bit_idx == bit_last_data) begin
							state <= RX_STOP;
							bit_idx <= bit_stop;
						end else begin
							bit_idx <= bit_idx + 4'd1;
						end
					end
				end
				RX_STOP: begin
					if (mid_sample) begin
						// Report, low stop bit flags a framing error
						rx_valid <= 1'b1;
						rx_data <= shift_q;
						rx_frame_err <= !rxd_sync;
						state <= RX_IDLE;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// One pulse per frame
	a_valid_single: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rx_valid |=> !rx_valid)
		else $error("rx_valid high for two cycles");

endmodule

`default_nettype wire

/* hw/uart_top.sv */
////////////////////////////////////////////////////////////
// UART subsystem, one tick shared by both engines
// baud_fixed = 0 takes the divisor from ext_baud_count
// Change the divisor only while both engines are idle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module uart_top #(
	parameter bit baud_fixed = 1'b0
) (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  uart_pkg::baud_count_t ext_baud_count,
	input  logic                  tx_req,
	input  uart_pkg::uart_byte_t  tx_data,
	output logic                  tx_busy,
	output logic                  txd,
	input  logic                  rxd,
	output logic                  rx_valid,
	output uart_pkg::uart_byte_t  rx_data,
	output logic                  rx_frame_err
);

	// 4x oversampling enable
	logic baud_tick;

	uart_baud_tick #(
		.baud_fixed(baud_fixed)
	) i_baud_tick (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.ext_baud_count(ext_baud_count),
		.baud_tick(baud_tick)
	);

	uart_transmitter i_tx (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.baud_tick(baud_tick),
		.tx_req(tx_req),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.txd(txd)
	);

	// Same tick, so loopback works at any divisor
	uart_receiver i_rx (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.baud_tick(baud_tick),
		.rxd(rxd),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_frame_err(rx_frame_err)
	);

endmodule

`default_nettype wire

/* hw/uart_transmitter.sv */
////////////////////////////////////////////////////////////
// 8N1 transmitter sending LSB first on the 4x tick
// Requests while busy are dropped and never queued
// Frame is 40 ticks plus up to one tick of start latency
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module uart_transmitter (
	input  logic                 iCLOCK,
	input  logic                 inRESET,
	input  logic                 baud_tick,
	input  logic                 tx_req,
	input  uart_pkg::uart_byte_t tx_data,
	output logic                 tx_busy,
	output logic                 txd
);
	import uart_pkg::*;

	// Last tick of a bit
	localparam sub_tick_t sub_last = sub_tick_t'(`UART_OVERSAMPLE - 1);
	// Stop bit position
	localparam bit_index_t bit_stop = 4'd9;

	tx_state_t  state;
	logic       busy_q;
	uart_byte_t data_q;
	bit_index_t bit_idx;
	sub_tick_t  sub_tick;

	// Line level for a frame position
	function automatic logic frame_bit(input bit_index_t idx, input uart_byte_t data);
		logic level;
		if (idx == 4'd0) begin
			// Start bit
			level = 1'b0;
		end else if (idx <= 4'd8) begin
			level = data[3'(idx - 4'd1)];
		end else begin
			// Stop bit
			level = 1'b1;
		end
		return level;
	endfunction

	// Byte is captured only on an accepted request
	always_ff @(posedge iCLOCK) begin
		if (tx_req && !busy_q) begin
			data_q <= tx_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= TX_IDLE;
			busy_q <= 1'b0;
			bit_idx <= '0;
			sub_tick <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (!busy_q) begin
						// Accept
						if (tx_req) begin
							busy_q <= 1'b1;
						end
					end else if (baud_tick) begin
						// Pending request starts its start bit on this tick
						state <= TX_SEND;
						bit_idx <= '0;
						sub_tick <= '0;
					end
				end
				TX_SEND: begin
					if (baud_tick) begin
						if (sub_tick == sub_last) begin
							sub_tick <= '0;
							if (bit_idx == bit_stop) begin
								// Stop bit done
								state <= TX_IDLE;
								busy_q <= 1'b0;
							end else begin
								bit_idx <= bit_idx + 4'd1;
							end
						end else begin
							sub_tick <= sub_tick + 2'd1;
						end
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	assign tx_busy = busy_q;
	// Idle line is high
	assign txd = (state == TX_SEND) ? frame_bit(bit_idx, data_q) : 1'b1;

	// No frame pending keeps the line high
	a_txd_idle_high: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!tx_busy |-> txd)
		else $error("txd low while transmitter idle");

	// Busy only falls at the end of the stop bit
	a_busy_whole_frame: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$fell(tx_busy) |-> $past(state == TX_SEND && bit_idx == bit_stop &&
			sub_tick == sub_last && baud_tick))
		else $error("tx_busy dropped mid-frame");

endmodule

`default_nettype wire

/* tb/tb_uart_top.sv */
////////////////////////////////////////////////////////////
// Self-checking testbench for uart_top, external divisor
// Cases come from tb/uart_golden.txt, run from project root
// Divisor changes only between cases, both engines idle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_uart_top;
	import uart_pkg::*;

	logic        iCLOCK = 1'b0;
	logic        inRESET;
	baud_count_t ext_baud_count;
	logic        tx_req;
	uart_byte_t  tx_data;
	logic        tx_busy;
	logic        txd;
	logic        rxd;
	logic        rx_valid;
	uart_byte_t  rx_data;
	logic        rx_frame_err;

	// Line source, loopback or driven by the bench
	logic loop_mode;
	logic rxd_drive;
	logic txd_loop = 1'b1;

	// Monitor totals, updated on the falling edge
	int         valid_total = 0;
	int         busy_cycles = 0;
	uart_byte_t last_data = '0;
	logic       last_err = 1'b0;

	int errors;
	int tests;
	bit aborted;
	// Tick period of the divisor in use
	int prev_period;

	uart_top #(
		.baud_fixed(1'b0)
	) i_dut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.ext_baud_count(ext_baud_count),
		.tx_req(tx_req),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.txd(txd),
		.rxd(rxd),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_frame_err(rx_frame_err)
	);

	// 10 ns period
	always begin
		#5 iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) begin
		txd_loop <= txd;
	end

	assign rxd = loop_mode ? txd_loop : rxd_drive;

	// Outputs are stable mid-cycle
	always @(negedge iCLOCK) begin
		if (tx_busy === 1'b1) begin
			busy_cycles <= busy_cycles + 1;
		end
		if (rx_valid === 1'b1) begin
			valid_total <= valid_total + 1;
			last_data <= rx_data;
			last_err <= rx_frame_err;
		end
	end

	// New divisor, then let the old period run out
	task automatic set_divisor(input int count);
		@(posedge iCLOCK);
		ext_baud_count <= 13'(count);
		repeat (prev_period + 2) @(posedge iCLOCK);
		prev_period = count + 1;
	endtask

	task automatic wait_valid(input int snap, input int limit, output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < limit) begin
			@(negedge iCLOCK);
			cycles++;
			if (valid_total > snap) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			$display("Timeout at %0t: no rx_valid within 50 bit times", $time);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_busy_low(input int limit, output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < limit) begin
			@(negedge iCLOCK);
			cycles++;
			if (tx_busy === 1'b0) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			$display("Timeout at %0t: tx_busy still high after 50 bit times", $time);
			errors++;
			aborted = 1'b1;
		end
	endtask

	// 8N1 frame on rxd, LSB first, stop level given
	task automatic drive_frame(input uart_byte_t data, input logic stop, input int period);
		logic [9:0] frame;
		int i;
		frame = {stop, data, 1'b0};
		@(posedge iCLOCK);
		for (i = 0; i < 10; i++) begin
			rxd_drive <= frame[0];
			frame = frame >> 1;
			repeat (4 * period) @(posedge iCLOCK);
		end
		rxd_drive <= 1'b1;
	endtask

	task automatic check_byte(input int snap, input uart_byte_t data, input logic flag);
		assert (valid_total - snap == 1) else begin
			$display("ERR %0t: %0d rx_valid pulses, expected 1", $time, valid_total - snap);
			errors++;
		end
		assert (last_data === data) else begin
			$display("ERR %0t: rx_data %h, expected %h", $time, last_data, data);
			errors++;
		end
		assert (last_err === flag) else begin
			$display("ERR %0t: rx_frame_err %b, expected %b", $time, last_err, flag);
			errors++;
		end
	endtask

	task automatic run_loopback(input uart_byte_t data, input logic flag, input int period);
		int v_snap;
		int b_snap;
		int b_len;
		bit ok;
		@(posedge iCLOCK);
		loop_mode <= 1'b1;
		repeat (2) @(posedge iCLOCK);
		tx_req <= 1'b1;
		tx_data <= data;
		v_snap = valid_total;
		b_snap = busy_cycles;
		@(posedge iCLOCK);
		tx_req <= 1'b0;
		tx_data <= ~data;
		@(negedge iCLOCK);
		assert (tx_busy === 1'b1) else begin
			$display("ERR %0t: tx_busy low on the cycle after tx_req", $time);
			errors++;
		end
		// Second request two bits in, dropped by the busy engine
		repeat (8 * period) @(posedge iCLOCK);
		tx_req <= 1'b1;
		@(posedge iCLOCK);
		tx_req <= 1'b0;
		wait_valid(v_snap, 200 * period, ok);
		if (ok) begin
			wait_busy_low(200 * period, ok);
		end
		if (ok) begin
			repeat (8 * period) @(negedge iCLOCK);
			check_byte(v_snap, data, flag);
			b_len = busy_cycles - b_snap;
			// 40 ticks plus start latency
			assert (b_len >= 39 * period && b_len <= 41 * period) else begin
				$display("ERR %0t: busy for %0d cycles, expected about %0d",
					$time, b_len, 40 * period);
				errors++;
			end
		end
		@(posedge iCLOCK);
		loop_mode <= 1'b0;
	endtask

	task automatic run_framing(input uart_byte_t data, input logic flag, input int period);
		int v_snap;
		bit ok;
		v_snap = valid_total;
		// Stop bit forced low
		drive_frame(data, 1'b0, period);
		wait_valid(v_snap, 200 * period, ok);
		if (ok) begin
			repeat (8 * period) @(negedge iCLOCK);
			check_byte(v_snap, data, flag);
		end
	endtask

	task automatic run_glitch(input int period);
		int v_snap;
		v_snap = valid_total;
		// Low for one tick only
		@(posedge iCLOCK);
		rxd_drive <= 1'b0;
		repeat (period) @(posedge iCLOCK);
		rxd_drive <= 1'b1;
		repeat (40 * period) @(negedge iCLOCK);
		assert (valid_total == v_snap) else begin
			$display("ERR %0t: rx_valid after a glitch on rxd", $time);
			errors++;
		end
	endtask

	task automatic run_case(input logic [7:0] mode, input int count, input uart_byte_t data,
		input logic flag);
		int err_before;
		int gap;
		tests++;
		err_before = errors;
		gap = int'($urandom % 16) + 1;
		repeat (gap) @(posedge iCLOCK);
		set_divisor(count);
		case (mode)
			"L": run_loopback(data, flag, count + 1);
			"F": run_framing(data, flag, count + 1);
			default: run_glitch(count + 1);
		endcase
		$display("test %0d mode %c count %0d byte %h: %s", tests, mode, count, data,
			(errors == err_before) ? "ok" : "failed");
	endtask

	initial begin
		int fd;
		int n;
		bit done;
		logic [8*80-1:0] line;
		logic [7:0] mode;
		int count;
		uart_byte_t data;
		int flag;
		inRESET = 1'b0;
		ext_baud_count = 13'd4;
		tx_req = 1'b0;
		tx_data = '0;
		rxd_drive = 1'b1;
		loop_mode = 1'b0;
		errors = 0;
		tests = 1;
		aborted = 1'b0;
		done = 1'b0;
		prev_period = 5;
		void'($urandom(23));
		repeat (2) @(posedge iCLOCK);
		inRESET <= 1'b1;
		@(negedge iCLOCK);
		assert (txd === 1'b1 && tx_busy === 1'b0 && rx_valid === 1'b0 && rx_data === 8'h00)
		else begin
			$display("ERR %0t: reset state txd %b busy %b valid %b data %h",
				$time, txd, tx_busy, rx_valid, rx_data);
			errors++;
		end
		$display("test 1 reset values: %s", (errors == 0) ? "ok" : "failed");
		fd = $fopen("tb/uart_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open tb/uart_golden.txt");
			errors++;
		end else begin
			while (!aborted && !done) begin
				n = $fscanf(fd, "%c", mode);
				if (n != 1) begin
					done = 1'b1;
				end else if (mode == "#") begin
					// Comment line
					void'($fgets(line, fd));
				end else if (mode == "L" || mode == "F" || mode == "G") begin
					n = $fscanf(fd, "%d %h %d", count, data, flag);
					if (n == 3) begin
						run_case(mode, count, data, flag[0]);
					end else begin
						$display("Malformed line in tb/uart_golden.txt");
						errors++;
						done = 1'b1;
					end
				end
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* tb/uart_golden.txt */
# mode count byte(hex) frame_err
# L loopback txd to rxd, F frame on rxd with low stop bit, G one-tick glitch on rxd
L 4 a5 0
L 4 00 0
L 7 ff 0
L 12 3c 0
L 20 81 0
F 4 5a 1
F 9 c3 1
G 4 00 0
L 4 96 0
G 11 00 0
L 11 e1 0
L 5 7e 0

/* verilog.f */
+incdir+hw
hw/uart_pkg.sv
hw/uart_baud_tick.sv
hw/uart_transmitter.sv
hw/uart_receiver.sv
hw/uart_top.sv
tb/tb_uart_top.sv
